// ==== logic/ppu_pkg.sv ====
package ppu_pkg;

  // ====================================================================
  // Operand widths.
  // ====================================================================

  localparam int MANT_W = 12;  // Includes the hidden one.
  localparam int TE_W   = 10;  // Signed total exponent.

  // ====================================================================
  // Vector types.
  // ====================================================================

  typedef logic signed [TE_W-1:0] exponent_t;

  // Mantissa in [1,2), one integer bit.
  typedef logic [MANT_W-1:0] mant_t;

  typedef logic [2*MANT_W-1:0] recip_t;  // Reciprocal, one integer bit.
  typedef logic [2*MANT_W-1:0] quot_t;   // Normalized quotient.

  // ====================================================================
  // Request, response and controller state.
  // ====================================================================

  typedef struct packed {
    logic      sign1;
    logic      sign2;
    exponent_t te1;
    exponent_t te2;
    mant_t     mant1;  // Dividend.
    mant_t     mant2;  // Divisor.
  } div_req_t;

  typedef struct packed {
    logic      sign;
    exponent_t te;
    quot_t     mant;
  } div_rsp_t;

  typedef enum logic [2:0] {IDLE, SEED, ITER, MUL, DONE} div_state_e;

endpackage

// ==== logic/div_ctrl.sv ====
`timescale 1ns/1ps

module div_ctrl
  import ppu_pkg::*;
#(
  parameter int NR_ITERS = 2
) (
  input  logic clk_i,
  input  logic rst,
  input  logic req_valid_i,
  input  logic rsp_ready_i,
  output logic req_ready_o,
  output logic accept_o,
  output logic seed_load_o,
  output logic nr_step_o,
  output logic mul_capture_o,
  output logic rsp_valid_o
);

  localparam int CNT_W = (NR_ITERS > 1) ? $clog2(NR_ITERS) : 1;
  localparam logic [CNT_W-1:0] LAST_ITER = CNT_W'(NR_ITERS - 1);

  div_state_e       state_q;
  div_state_e       state_d;
  logic [CNT_W-1:0] iter_cnt_q;
  logic             last_iter;

  assign last_iter = (iter_cnt_q == LAST_ITER);

  // ====================================================================
  // Next state.
  // ====================================================================

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          state_d = SEED;
        end
      end
      SEED: begin
        state_d = ITER;
      end
      ITER: begin
        if (last_iter) begin
          state_d = MUL;
        end
      end
      MUL: begin
        state_d = DONE;
      end
      DONE: begin
        // Hold the response until it is taken.
        if (rsp_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      state_q    <= IDLE;
      iter_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == SEED) begin
        iter_cnt_q <= '0;  // Restart for this operation.
      end else if (state_q == ITER) begin
        iter_cnt_q <= iter_cnt_q + 1'b1;
      end
    end
  end

  // ====================================================================
  // Strobes, one per step.
  // ====================================================================

  assign req_ready_o   = (state_q == IDLE);
  assign accept_o      = req_ready_o & req_valid_i;
  assign seed_load_o   = (state_q == SEED);
  assign nr_step_o     = (state_q == ITER);
  assign mul_capture_o = (state_q == MUL);
  assign rsp_valid_o   = (state_q == DONE);

endmodule

// ==== logic/recip_seed_lut.sv ====
`timescale 1ns/1ps

module recip_seed_lut
  import ppu_pkg::*;
#(
  parameter int SEED_BITS = 6
) (
  input  mant_t  mant_i,
  output recip_t seed_o
);

  localparam int ENTRIES = 2 ** SEED_BITS;
  localparam int FRAC    = 2 * MANT_W - 1;  // Fraction bits of recip_t.

  typedef recip_t seed_table_t [ENTRIES];

  // Entry i covers d in [1 + i/2^S, 1 + (i+1)/2^S).
  // Its value is 1/mid = 2^(S+1) / (2^(S+1) + 2i + 1).
  function automatic seed_table_t build_table();
    seed_table_t tbl;
    logic [63:0] num;
    logic [63:0] den;
    num    = 64'd1 << (FRAC + SEED_BITS + 1);
    tbl[0] = recip_t'(1) << FRAC;  // Exactly one.
    for (int i = 1; i < ENTRIES; i++) begin
      den    = (64'd1 << (SEED_BITS + 1)) + 64'(2 * i + 1);
      tbl[i] = recip_t'(num / den);
    end
    return tbl;
  endfunction

  localparam seed_table_t SEED_TABLE = build_table();

  logic [SEED_BITS-1:0] addr;

  // Leading fraction bits, just below the hidden one.
  assign addr   = mant_i[MANT_W-2 -: SEED_BITS];
  assign seed_o = SEED_TABLE[addr];

endmodule

// ==== logic/newton_raphson.sv ====
`timescale 1ns/1ps

module newton_raphson
  import ppu_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst,
  input  logic   load_i,
  input  logic   step_i,
  input  mant_t  d_i,
  input  recip_t seed_i,
  output recip_t x_o
);

  // d*x carries 11 + 23 fraction bits.
  localparam int PROD_W    = 3 * MANT_W;
  localparam int PROD_FRAC = 3 * MANT_W - 2;
  localparam int FULL_W    = 2 * MANT_W + PROD_W;

  localparam logic [PROD_W-1:0] TWO = PROD_W'(1) << (PROD_FRAC + 1);

  recip_t            x_q;
  recip_t            x_next;
  logic [PROD_W-1:0] dx;
  logic [PROD_W-1:0] corr;
  logic [FULL_W-1:0] x_corr;

  // ====================================================================
  // One iteration, x * (2 - d*x).
  // ====================================================================

  assign dx     = d_i * x_q;
  assign corr   = TWO - dx;
  assign x_corr = x_q * corr;

  // Truncation keeps the estimate at or below 1/d.
  assign x_next = x_corr[PROD_FRAC +: 2*MANT_W];

  always_ff @(posedge clk_i) begin
    if (rst) begin
      x_q <= '0;
    end else if (load_i) begin
      x_q <= seed_i;
    end else if (step_i) begin
      x_q <= x_next;
    end
  end

  assign x_o = x_q;

endmodule

// ==== logic/mant_mul_norm.sv ====
`timescale 1ns/1ps

module mant_mul_norm
  import ppu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst,
  input  logic      capture_i,
  input  logic      sign1_i,
  input  logic      sign2_i,
  input  exponent_t te1_i,
  input  exponent_t te2_i,
  input  mant_t     mant1_i,
  input  recip_t    recip_i,
  output div_rsp_t  rsp_o
);

  localparam int PROD_W = 3 * MANT_W;  // 2 integer bits, 34 fraction bits.
  localparam int INT_B  = PROD_W - 2;  // Weight one.

  localparam quot_t QUOT_ONE = quot_t'(1) << (2 * MANT_W - 1);

  logic [PROD_W-1:0] prod;
  logic              int_bit;
  logic              near_one;
  exponent_t         te_diff;
  quot_t             quot_n;
  exponent_t         te_n;
  div_rsp_t          rsp_q;

  assign prod    = mant1_i * recip_i;
  assign int_bit = prod[INT_B];
  assign te_diff = te1_i - te2_i;

  // Quotients of MANT_W-bit mantissas never fall within 2^-(MANT_W+1) below one
  // unless they are equal, so a product in that window is exactly one.
  assign near_one = ~int_bit & (&prod[INT_B-1 -: MANT_W+1]);

  // ====================================================================
  // Normalization into [1,2).
  // ====================================================================

  always_comb begin
    if (int_bit) begin
      quot_n = prod[INT_B -: 2*MANT_W];
      te_n   = te_diff;
    end else if (near_one) begin
      quot_n = QUOT_ONE;
      te_n   = te_diff;
    end else begin
      quot_n = prod[INT_B-1 -: 2*MANT_W];  // Below one, shift left.
      te_n   = te_diff - exponent_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      rsp_q <= '0;
    end else if (capture_i) begin
      rsp_q.sign <= sign1_i ^ sign2_i;
      rsp_q.te   <= te_n;
      rsp_q.mant <= quot_n;
    end
  end

  assign rsp_o = rsp_q;

endmodule

// ==== logic/core_div_top.sv ====
`timescale 1ns/1ps

module core_div_top
  import ppu_pkg::*;
#(
  parameter int NR_ITERS  = 2,
  parameter int SEED_BITS = 6
) (
  input  logic     clk_i,
  input  logic     rst,
  input  div_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output div_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i
);

  div_req_t req_q;
  logic     accept;
  logic     seed_load;
  logic     nr_step;
  logic     mul_capture;
  recip_t   seed;
  recip_t   recip;

  // Operands stay put for the whole operation.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  // ====================================================================
  // Control.
  // ====================================================================

  div_ctrl #(
    .NR_ITERS (NR_ITERS)
  ) u_div_ctrl (
    .clk_i         (clk_i),
    .rst           (rst),
    .req_valid_i   (req_valid_i),
    .rsp_ready_i   (rsp_ready_i),
    .req_ready_o   (req_ready_o),
    .accept_o      (accept),
    .seed_load_o   (seed_load),
    .nr_step_o     (nr_step),
    .mul_capture_o (mul_capture),
    .rsp_valid_o   (rsp_valid_o)
  );

  // ====================================================================
  // Datapath.
  // ====================================================================

  recip_seed_lut #(
    .SEED_BITS (SEED_BITS)
  ) u_recip_seed_lut (
    .mant_i (req_q.mant2),
    .seed_o (seed)
  );

  newton_raphson u_newton_raphson (
    .clk_i  (clk_i),
    .rst    (rst),
    .load_i (seed_load),
    .step_i (nr_step),
    .d_i    (req_q.mant2),
    .seed_i (seed),
    .x_o    (recip)
  );

  mant_mul_norm u_mant_mul_norm (
    .clk_i     (clk_i),
    .rst       (rst),
    .capture_i (mul_capture),
    .sign1_i   (req_q.sign1),
    .sign2_i   (req_q.sign2),
    .te1_i     (req_q.te1),
    .te2_i     (req_q.te2),
    .mant1_i   (req_q.mant1),
    .recip_i   (recip),
    .rsp_o     (rsp_o)  // Held until the next capture.
  );

endmodule

// ==== dv/core_div_props.sv ====
`timescale 1ns/1ps

module core_div_props
  import ppu_pkg::*;
#(
  parameter int NR_ITERS = 2
) (
  input logic     clk_i,
  input logic     rst,
  input logic     req_valid_i,
  input logic     req_ready_i,
  input div_rsp_t rsp_i,
  input logic     rsp_valid_i,
  input logic     rsp_ready_i
);

  localparam int GAP = NR_ITERS + 2;  // Cycles with valid low after accept.

  int unsigned fail_cnt = 0;
  logic        accept;
  logic        taken;

  assign accept = req_valid_i & req_ready_i;
  assign taken  = rsp_valid_i & rsp_ready_i;

  // ====================================================================
  // Reset, latency and handshake.
  // ====================================================================

  a_reset_idle: assert property (@(posedge clk_i) rst |=> !rsp_valid_i && req_ready_i)
    else begin
      $error("Outputs not idle after reset.");
      fail_cnt++;
    end

  a_latency: assert property (@(posedge clk_i) disable iff (rst)
    accept |=> !rsp_valid_i [*GAP] ##1 rsp_valid_i)
    else begin
      $error("Response valid did not rise NR_ITERS+3 cycles after accept.");
      fail_cnt++;
    end

  a_rsp_hold: assert property (@(posedge clk_i) disable iff (rst)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else begin
      $error("Response dropped or changed under back-pressure.");
      fail_cnt++;
    end

  a_busy: assert property (@(posedge clk_i) disable iff (rst)
    (accept || (!req_ready_i && !taken)) |=> !req_ready_i)
    else begin
      $error("Request ready rose before the response was taken.");
      fail_cnt++;
    end

  a_ready_again: assert property (@(posedge clk_i) disable iff (rst) taken |=> req_ready_i)
    else begin
      $error("Request ready low after the response was taken.");
      fail_cnt++;
    end

  // Quotient always normalized.
  a_norm: assert property (@(posedge clk_i) disable iff (rst)
    rsp_valid_i |-> rsp_i.mant[2*MANT_W-1])
    else begin
      $error("Response mantissa top bit is clear.");
      fail_cnt++;
    end

endmodule

// ==== dv/tb_core_div.sv ====
`timescale 1ns/1ps

module tb_core_div
  import ppu_pkg::*;
();

  localparam int NR_ITERS = 2;
  localparam int N_RANDOM = 40;
  localparam int TIMEOUT  = 200;  // Cycles per wait.
  localparam int QUOT_W   = 2 * MANT_W;

  logic     clk_i = 1'b0;
  logic     rst;
  div_req_t req_i;
  logic     req_valid_i;
  logic     req_ready_o;
  div_rsp_t rsp_o;
  logic     rsp_valid_o;
  logic     rsp_ready_i;
  integer   seed;
  int       value_errs;
  int       proto_errs;
  int       rsp_count;
  int       hold_cnt;
  string    cur_name;
  div_req_t stim_q[$];
  string    stim_name_q[$];
  div_req_t pend_q[$];
  string    pend_name_q[$];

  always #50 clk_i = ~clk_i;

  core_div_top #(.NR_ITERS(NR_ITERS), .SEED_BITS(6)) u_core_div_top (.*);

  bind core_div_top core_div_props #(.NR_ITERS(NR_ITERS)) u_core_div_props (
    .clk_i(clk_i), .rst(rst), .req_valid_i(req_valid_i), .req_ready_i(req_ready_o),
    .rsp_i(rsp_o), .rsp_valid_i(rsp_valid_o), .rsp_ready_i(rsp_ready_i));

  // ====================================================================
  // Reference model and checks.
  // ====================================================================

  task automatic check_rsp(input string name, input div_req_t r, input div_rsp_t rsp);
    logic        lt;
    exponent_t   exp_te;
    logic [63:0] ref_q;
    lt     = (r.mant1 < r.mant2);
    exp_te = exponent_t'(int'(r.te1) - int'(r.te2) - int'(lt));
    // Scale so the exact quotient lands in [1,2).
    ref_q  = (64'(r.mant1) << (lt ? QUOT_W : QUOT_W - 1)) / 64'(r.mant2);
    assert (rsp.sign == (r.sign1 ^ r.sign2)) else begin
      value_errs++;
      $display("MISMATCH %s sign: expected %0b actual %0b", name, r.sign1 ^ r.sign2, rsp.sign);
    end
    assert (rsp.te == exp_te) else begin
      value_errs++;
      $display("MISMATCH %s te: expected %0d actual %0d", name, exp_te, rsp.te);
    end
    assert ((r.mant1 == r.mant2) ? (64'(rsp.mant) == ref_q) :
            (64'(rsp.mant) <= ref_q && ref_q - 64'(rsp.mant) <= 64'(1 << (MANT_W - 2))
             && rsp.mant[QUOT_W-1])) else begin
      value_errs++;
      $display("MISMATCH %s mant: expected %h actual %h", name, ref_q[QUOT_W-1:0], rsp.mant);
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst && req_valid_i && req_ready_o) begin
      pend_q.push_back(req_i);
      pend_name_q.push_back(cur_name);
    end
    if (!rst && rsp_valid_o && rsp_ready_i) begin
      rsp_count++;
      if (pend_q.size() == 0) begin
        proto_errs++;
        $display("Response arrived with no request pending.");
      end else begin
        check_rsp(pend_name_q.pop_front(), pend_q.pop_front(), rsp_o);
      end
    end
  end

  // Hold off responses for a few cycles now and then.
  always @(negedge clk_i) begin
    if (hold_cnt > 0) begin
      rsp_ready_i = 1'b0;
      hold_cnt--;
    end else if (($random(seed) & 3) == 0) begin
      rsp_ready_i = 1'b0;
      hold_cnt    = $random(seed) & 7;
    end else begin
      rsp_ready_i = 1'b1;
    end
  end

  // ====================================================================
  // Stimulus.
  // ====================================================================

  task automatic add_case(input string name, input logic s1, input logic s2, input int e1,
                          input int e2, input mant_t m1, input mant_t m2);
    div_req_t r;
    r = '{sign1: s1, sign2: s2, te1: exponent_t'(e1), te2: exponent_t'(e2),
          mant1: m1, mant2: m2};
    stim_q.push_back(r);
    stim_name_q.push_back(name);
  endtask

  task automatic build_stimulus();
    logic  s1;
    logic  s2;
    int    e1;
    int    e2;
    mant_t m1;
    mant_t m2;
    add_case("one_by_one", 1'b0, 1'b0, 3, 1, 12'h800, 12'h800);
    add_case("one_by_max", 1'b0, 1'b1, 0, 0, 12'h800, 12'hfff);
    add_case("max_by_one", 1'b1, 1'b0, 5, -2, 12'hfff, 12'h800);
    add_case("equal_ops", 1'b1, 1'b1, 7, 7, 12'ha53, 12'ha53);
    add_case("neg_exp", 1'b1, 1'b0, -100, 50, 12'h9c4, 12'hc01);
    add_case("neg_both", 1'b0, 1'b1, -7, -250, 12'hd77, 12'h8a2);
    for (int i = 0; i < N_RANDOM; i++) begin
      s1 = 1'($random(seed));
      s2 = 1'($random(seed));
      e1 = $random(seed) % 200;
      e2 = $random(seed) % 200;
      m1 = 12'h800 | 12'($random(seed));
      m2 = 12'h800 | 12'($random(seed));
      add_case($sformatf("rand_%0d", i), s1, s2, e1, e2, m1, m2);
    end
  endtask

  task automatic send_req(input string name, input div_req_t r, output bit ok);
    int waited;
    waited      = 0;
    cur_name    = name;
    req_i       = r;
    req_valid_i = 1'b1;
    while (!req_ready_o && waited < TIMEOUT) begin
      waited++;
      @(negedge clk_i);
    end
    ok = req_ready_o;
    if (!ok) begin
      proto_errs++;
      $display("Timed out waiting for the DUT to accept request %s.", name);
    end else begin
      @(negedge clk_i);  // Accepted on the rising edge in between.
    end
    req_valid_i = 1'b0;
  endtask

  task automatic wait_drain(output bit ok);
    int waited;
    waited = 0;
    while (rsp_count < stim_q.size() && waited < TIMEOUT) begin
      waited++;
      @(negedge clk_i);
    end
    ok = (rsp_count == stim_q.size()) && (pend_q.size() == 0);
    if (!ok) begin
      proto_errs++;
      $display("Timed out with %0d of %0d responses received.", rsp_count, stim_q.size());
    end
  endtask

  initial begin
    bit ok;
    int assert_errs;
    rst         = 1'b1;
    req_i       = '0;
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b0;
    seed        = 32'h5b0c;
    value_errs  = 0;
    proto_errs  = 0;
    rsp_count   = 0;
    hold_cnt    = 0;
    cur_name    = "none";
    ok          = 1'b1;
    build_stimulus();
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst = 1'b0;
    foreach (stim_q[i]) begin
      if (ok) begin
        send_req(stim_name_q[i], stim_q[i], ok);
      end
    end
    if (ok) begin
      wait_drain(ok);
    end
    assert_errs = u_core_div_top.u_core_div_props.fail_cnt;
    $display("Errors: %0d value, %0d protocol, %0d assertion; %0d responses",
             value_errs, proto_errs, assert_errs, rsp_count);
    if (value_errs + proto_errs + assert_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
logic/ppu_pkg.sv
logic/div_ctrl.sv
logic/recip_seed_lut.sv
logic/newton_raphson.sv
logic/mant_mul_norm.sv
logic/core_div_top.sv
dv/core_div_props.sv
dv/tb_core_div.sv
